// ==== all.f ====
hw/lpif_pkg.sv
hw/aib_pkg.sv
hw/lpif_lsm.sv
hw/lpif_tx_stage.sv
hw/lpif_lpbk_stage.sv
hw/lpif_rx_stage.sv
hw/lpif_top.sv
verif/tb_lpif.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LPIF adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_lpif -o tb_lpif
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_lpif)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

// ==== verif/tb_lpif.sv ====
/*
 * Testbench for the LPIF to AIB adapter
 * Runs reset, link bring-up, loopback and far-side flits, the unknown
 * stream drop and the L1 stall exchange against a cycle model
 */

`timescale 1ns/1ps
`default_nettype none

module tb_lpif;

  localparam int MAX_CYCLES = 400;

  typedef struct packed
  {
    logic [63:0] data;
    logic [1:0]  valid;
    logic [7:0]  stream;
  } flit_t;

  typedef struct packed
  {
    logic [31:0] due;  // Cycle the frame shows on the receive outputs
    flit_t       f;
  } rx_exp_t;

  logic                 lclk;
  logic                 arst_n;
  logic                 lp_irdy;
  logic [63:0]          lp_data;
  logic [1:0]           lp_valid;
  logic [7:0]           lp_stream;
  logic                 pl_trdy;
  logic                 pl_error;
  lpif_pkg::lnk_state_e lp_state_req;
  logic                 lp_stallack;
  logic                 fs_mac_rdy;
  lpif_pkg::lnk_state_e pl_state_sts;
  logic                 pl_stallreq;
  logic                 pl_phyinl1;
  logic                 pl_lnk_up;
  logic                 lpbk_en;
  logic [79:0]          dout;
  logic [79:0]          data_in_f;
  logic [63:0]          pl_data;
  logic [1:0]           pl_valid;
  logic [7:0]           pl_stream;

  // Cycle model state
  logic [31:0]          cycle = '0;
  int                   value_errors = 0;
  int                   event_errors = 0;
  logic [31:0]          rng = 32'd14;
  lpif_pkg::lnk_state_e m_state = lpif_pkg::RESET;
  lpif_pkg::lnk_state_e m_next;
  flit_t                tx_flit;
  logic                 tx_live = 1'b0;  // Frame on data_in_f
  flit_t                src_flit;
  logic                 src_live;
  logic                 accept;
  logic [1:0]           tx_protid;
  rx_exp_t              exp_entry;
  rx_exp_t              exp_head;
  rx_exp_t              exp_q[$];
  lpif_pkg::lnk_state_e exp_sts = lpif_pkg::RESET;
  logic                 exp_trdy = 1'b0;
  logic                 exp_lnk_up = 1'b0;
  logic                 exp_stallreq = 1'b0;
  logic                 exp_phyinl1 = 1'b0;
  logic                 exp_error = 1'b0;
  logic [79:0]          exp_word = '0;
  flit_t                f;
  int                   i;

  lpif_top dut0 (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic flit_t random_flit();
    flit_t r;
    r.data   = {rand_word(), rand_word()};
    r.valid  = 2'(rand_word() % 32'd3) + 2'd1;  // Never both halves empty
    r.stream = 8'(rand_word() % 32'd3) + 8'd1;  // Legal IDs 01 to 03
    return r;
  endfunction

  function automatic logic [1:0] stream_to_protid(input logic [7:0] stream);
    case (stream)
      8'h01:   return 2'd1;
      8'h02:   return 2'd2;
      8'h03:   return 2'd3;
      default: return 2'd0;  // Unknown stream is dropped
    endcase
  endfunction

  function automatic logic [7:0] protid_to_stream(input logic [1:0] protid);
    case (protid)
      2'd1:    return 8'h01;
      2'd2:    return 8'h02;
      2'd3:    return 8'h03;
      default: return 8'h00;
    endcase
  endfunction

  // Protocol ID in [1:0], valid in [3:2], data in [67:4]
  function automatic logic [79:0] pack_frame(input logic [1:0] protid, input flit_t fl);
    logic [79:0] w;
    w       = '0;
    w[1:0]  = protid;
    w[3:2]  = fl.valid;
    w[67:4] = fl.data;
    return w;
  endfunction

  task automatic check_field(input string name, input logic [79:0] got,
                             input logic [79:0] want);
    assert (got === want)
    else
    begin
      value_errors++;
      $display("[FAIL] cycle %0d %s: got 0x%0h, expected 0x%0h", cycle, name, got, want);
    end
  endtask

  task automatic report_event(input string what);
    event_errors++;
    $display("Error at cycle %0d: %s", cycle, what);
  endtask

  task automatic wait_edge();
    @(posedge lclk);
    #1;  // Inputs change just after the edge
  endtask

  task automatic offer_flit(input flit_t fl);
    lp_irdy   = 1'b1;
    lp_data   = fl.data;
    lp_valid  = fl.valid;
    lp_stream = fl.stream;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, timeout and cycle model
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    lclk = 1'b0;
    forever #2 lclk = ~lclk;
  end

  always @(posedge lclk)
  begin
    cycle = cycle + 32'd1;
    if (cycle >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycle);
      $display("Errors: %0d value, %0d protocol", value_errors, event_errors);
      $display("TB FAILED");
      $finish;
    end
    else if (!arst_n)
    begin
      m_state      = lpif_pkg::RESET;
      tx_live      = 1'b0;
      exp_sts      = lpif_pkg::RESET;
      exp_trdy     = 1'b0;
      exp_lnk_up   = 1'b0;
      exp_stallreq = 1'b0;
      exp_phyinl1  = 1'b0;
      exp_error    = 1'b0;
      exp_word     = '0;
      exp_q.delete();
    end
    else
    begin
      // Receive lane source picked up at this edge
      if (lpbk_en)
      begin
        src_live = tx_live;
        src_flit = tx_flit;
      end
      else
      begin
        src_live        = (dout[1:0] != 2'd0);
        src_flit.data   = dout[67:4];
        src_flit.valid  = dout[3:2];
        src_flit.stream = protid_to_stream(dout[1:0]);
      end
      accept         = lp_irdy && (m_state == lpif_pkg::ACTIVE);  // State before the edge
      tx_protid      = stream_to_protid(lp_stream);
      tx_flit.data   = lp_data;
      tx_flit.valid  = lp_valid;
      tx_flit.stream = lp_stream;
      tx_live        = accept && (tx_protid != 2'd0);
      exp_error      = accept && (tx_protid == 2'd0);
      exp_word       = tx_live ? pack_frame(tx_protid, tx_flit) : '0;

      m_next = m_state;
      if (!fs_mac_rdy)
        m_next = lpif_pkg::RESET;
      else
      begin
        case (m_state)
          lpif_pkg::RESET:  if (lp_state_req == lpif_pkg::ACTIVE) m_next = lpif_pkg::ACTIVE;
          lpif_pkg::ACTIVE: if (lp_state_req == lpif_pkg::L1) m_next = lpif_pkg::STALL;
          lpif_pkg::STALL:  if (lp_stallack) m_next = lpif_pkg::L1;
          lpif_pkg::L1:     if (lp_state_req == lpif_pkg::ACTIVE) m_next = lpif_pkg::ACTIVE;
          default:          m_next = lpif_pkg::RESET;
        endcase
      end
      m_state = m_next;
      if (m_state == lpif_pkg::STALL)
        exp_sts = lpif_pkg::ACTIVE;
      else
        exp_sts = m_state;
      exp_trdy     = (m_state == lpif_pkg::ACTIVE);
      exp_lnk_up   = (m_state != lpif_pkg::RESET);
      exp_stallreq = (m_state == lpif_pkg::STALL);
      exp_phyinl1  = (m_state == lpif_pkg::L1);

      // Deframed one edge later if the link is active then
      if (src_live && (m_state == lpif_pkg::ACTIVE))
      begin
        exp_entry.due = cycle + 32'd1;
        exp_entry.f   = src_flit;
        exp_q.push_back(exp_entry);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Mid-cycle when all registered outputs have settled
  always @(negedge lclk)
  begin
    check_field("pl_state_sts", 80'(pl_state_sts), 80'(exp_sts));
    check_field("pl_trdy", 80'(pl_trdy), 80'(exp_trdy));
    check_field("pl_lnk_up", 80'(pl_lnk_up), 80'(exp_lnk_up));
    check_field("pl_stallreq", 80'(pl_stallreq), 80'(exp_stallreq));
    check_field("pl_phyinl1", 80'(pl_phyinl1), 80'(exp_phyinl1));
    check_field("pl_error", 80'(pl_error), 80'(exp_error));
    check_field("data_in_f", data_in_f, exp_word);
    if ((exp_q.size() != 0) && (exp_q[0].due == cycle))
    begin
      exp_head = exp_q.pop_front();
      check_field("pl_valid", 80'(pl_valid), 80'(exp_head.f.valid));
      check_field("pl_data", 80'(pl_data), 80'(exp_head.f.data));
      check_field("pl_stream", 80'(pl_stream), 80'(exp_head.f.stream));
    end
    else
      check_field("pl_valid", 80'(pl_valid), 80'd0);
  end

  assert property (@(posedge lclk) disable iff (!arst_n) pl_error |-> (data_in_f == '0))
  else report_event("pl_error was high with a nonzero word on data_in_f");

  assert property (@(posedge lclk) disable iff (!arst_n) pl_stallreq |-> !pl_trdy)
  else report_event("pl_trdy was high during the stall request");

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    arst_n       = 1'b0;
    lp_irdy      = 1'b0;
    lp_data      = '0;
    lp_valid     = '0;
    lp_stream    = '0;
    lp_state_req = lpif_pkg::RESET;
    lp_stallack  = 1'b0;
    fs_mac_rdy   = 1'b0;
    lpbk_en      = 1'b1;
    dout         = '0;
    offer_flit(random_flit());  // Held through reset and never taken
    repeat (8) @(posedge lclk);
    #1;
    arst_n = 1'b1;
    wait_edge();
    wait_edge();
    lp_irdy = 1'b0;

    // Bring-up
    fs_mac_rdy   = 1'b1;
    lp_state_req = lpif_pkg::ACTIVE;
    while (!pl_trdy)
      wait_edge();

    // Back-to-back loopback flits with one unknown stream among them
    for (i = 0; i < 30; i++)
    begin
      f = random_flit();
      if (i == 20)
        f.stream = 8'h7E;
      offer_flit(f);
      wait_edge();
    end
    lp_irdy = 1'b0;
    repeat (4) wait_edge();

    // Far-side lanes with every fourth word idle
    lpbk_en = 1'b0;
    for (i = 0; i < 16; i++)
    begin
      f    = random_flit();
      dout = pack_frame((i % 4 == 3) ? 2'd0 : stream_to_protid(f.stream), f);
      wait_edge();
    end
    dout = '0;
    repeat (4) wait_edge();

    // L1 entry with a flit held during stall and L1
    lpbk_en      = 1'b1;
    lp_state_req = lpif_pkg::L1;
    while (!pl_stallreq)
      wait_edge();
    offer_flit(random_flit());
    repeat (3) wait_edge();
    lp_stallack = 1'b1;
    while (!pl_phyinl1)
      wait_edge();
    lp_stallack = 1'b0;

    // Far-side frames in L1 never reach the receive outputs
    lpbk_en = 1'b0;
    f       = random_flit();
    dout    = pack_frame(stream_to_protid(f.stream), f);
    repeat (3) wait_edge();
    lpbk_en      = 1'b1;
    dout         = '0;
    lp_state_req = lpif_pkg::ACTIVE;
    while (!pl_trdy)
      wait_edge();
    wait_edge();
    lp_irdy = 1'b0;
    repeat (4) wait_edge();

    // Far side drops the link
    fs_mac_rdy = 1'b0;
    while (pl_state_sts != lpif_pkg::RESET)
      wait_edge();
    repeat (2) wait_edge();

    if (exp_q.size() != 0)
      report_event("receive frames were still expected at the end of the run");
    $display("Errors: %0d value, %0d protocol", value_errors, event_errors);
    if ((value_errors == 0) && (event_errors == 0))
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/lpif_top.sv ====
/*
 * LPIF to AIB adapter, single lclk domain
 * Transmit framing, loopback select and receive deframing in a row,
 * with the link state machine gating traffic
 */

`timescale 1ns/1ps
`default_nettype none

module lpif_top
  #(
  parameter lpif_pkg::lpif_stream_t MEM_CACHE_STREAM_ID = 8'h01,
  parameter lpif_pkg::lpif_stream_t IO_STREAM_ID        = 8'h02,
  parameter lpif_pkg::lpif_stream_t ARB_MUX_STREAM_ID   = 8'h03
  )
  (
  input  logic                   lclk,
  input  logic                   arst_n,
  // LPIF transmit
  input  logic                   lp_irdy,
  input  lpif_pkg::lpif_data_t   lp_data,
  input  lpif_pkg::lpif_valid_t  lp_valid,
  input  lpif_pkg::lpif_stream_t lp_stream,
  output logic                   pl_trdy,
  output logic                   pl_error,
  // Link state
  input  lpif_pkg::lnk_state_e   lp_state_req,
  input  logic                   lp_stallack,
  input  logic                   fs_mac_rdy,
  output lpif_pkg::lnk_state_e   pl_state_sts,
  output logic                   pl_stallreq,
  output logic                   pl_phyinl1,
  output logic                   pl_lnk_up,
  // AIB lanes
  input  logic                   lpbk_en,
  input  aib_pkg::lane_word_t    dout,
  output aib_pkg::lane_word_t    data_in_f,
  // LPIF receive
  output lpif_pkg::lpif_data_t   pl_data,
  output lpif_pkg::lpif_valid_t  pl_valid,
  output lpif_pkg::lpif_stream_t pl_stream
  );

  logic                link_active;
  aib_pkg::lane_word_t rx_lanes;

  lpif_lsm lpif_lsm_i
    (
    .lclk         (lclk),
    .arst_n       (arst_n),
    .lp_state_req (lp_state_req),
    .fs_mac_rdy   (fs_mac_rdy),
    .lp_stallack  (lp_stallack),
    .pl_state_sts (pl_state_sts),
    .pl_stallreq  (pl_stallreq),
    .pl_phyinl1   (pl_phyinl1),
    .pl_lnk_up    (pl_lnk_up),
    .link_active  (link_active)
    );

  lpif_tx_stage
    #(
    .MEM_CACHE_STREAM_ID (MEM_CACHE_STREAM_ID),
    .IO_STREAM_ID        (IO_STREAM_ID),
    .ARB_MUX_STREAM_ID   (ARB_MUX_STREAM_ID)
    )
  lpif_tx_stage_i
    (
    .lclk        (lclk),
    .arst_n      (arst_n),
    .link_active (link_active),
    .lp_irdy     (lp_irdy),
    .lp_data     (lp_data),
    .lp_valid    (lp_valid),
    .lp_stream   (lp_stream),
    .pl_trdy     (pl_trdy),
    .data_in_f   (data_in_f),
    .pl_error    (pl_error)
    );

  // Transmit word feeds both the AIB port and the loopback path
  lpif_lpbk_stage lpif_lpbk_stage_i
    (
    .lclk     (lclk),
    .arst_n   (arst_n),
    .lpbk_en  (lpbk_en),
    .tx_lanes (data_in_f),
    .dout     (dout),
    .rx_lanes (rx_lanes)
    );

  lpif_rx_stage
    #(
    .MEM_CACHE_STREAM_ID (MEM_CACHE_STREAM_ID),
    .IO_STREAM_ID        (IO_STREAM_ID),
    .ARB_MUX_STREAM_ID   (ARB_MUX_STREAM_ID)
    )
  lpif_rx_stage_i
    (
    .lclk        (lclk),
    .arst_n      (arst_n),
    .link_active (link_active),
    .rx_lanes    (rx_lanes),
    .pl_data     (pl_data),
    .pl_valid    (pl_valid),
    .pl_stream   (pl_stream)
    );

endmodule

`default_nettype wire

// ==== hw/lpif_rx_stage.sv ====
/*
 * Receive deframing stage
 * Unpacks the AIB lane word, maps the protocol ID back to a stream ID
 * and registers the LPIF receive outputs
 */

`timescale 1ns/1ps
`default_nettype none

module lpif_rx_stage
  #(
  parameter lpif_pkg::lpif_stream_t MEM_CACHE_STREAM_ID = 8'h01,
  parameter lpif_pkg::lpif_stream_t IO_STREAM_ID        = 8'h02,
  parameter lpif_pkg::lpif_stream_t ARB_MUX_STREAM_ID   = 8'h03
  )
  (
  input  logic                   lclk,
  input  logic                   arst_n,
  input  logic                   link_active,
  input  aib_pkg::lane_word_t    rx_lanes,
  output lpif_pkg::lpif_data_t   pl_data,
  output lpif_pkg::lpif_valid_t  pl_valid,
  output lpif_pkg::lpif_stream_t pl_stream
  );

  localparam int PROTID_W = $bits(lpif_pkg::protid_t);
  localparam int VALID_W  = $bits(lpif_pkg::lpif_valid_t);
  localparam int DATA_W   = $bits(lpif_pkg::lpif_data_t);

  lpif_pkg::protid_t      rx_protid;
  lpif_pkg::lpif_valid_t  rx_dvalid;
  lpif_pkg::lpif_data_t   rx_data;
  lpif_pkg::lpif_stream_t rx_stream;
  logic                   frame_vld;

  // Field extraction
  assign rx_protid = rx_lanes[aib_pkg::FRAME_PROTID_LSB +: PROTID_W];
  assign rx_dvalid = rx_lanes[aib_pkg::FRAME_DVALID_LSB +: VALID_W];
  assign rx_data   = rx_lanes[aib_pkg::FRAME_DATA_LSB +: DATA_W];

  // Idle frames and frames during stall or L1 are dropped
  assign frame_vld = (rx_protid != lpif_pkg::PROTID_IDLE) && link_active;

  // Reverse of the transmit map
  always_comb
  begin
    case (rx_protid)
      lpif_pkg::PROTID_MEM_CACHE: rx_stream = MEM_CACHE_STREAM_ID;
      lpif_pkg::PROTID_IO:        rx_stream = IO_STREAM_ID;
      lpif_pkg::PROTID_ARB_MUX:   rx_stream = ARB_MUX_STREAM_ID;
      default:                    rx_stream = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
      pl_valid <= '0;
    else
      pl_valid <= frame_vld ? rx_dvalid : '0;
  end

  // Payload only loads with a live frame
  always_ff @(posedge lclk)
  begin
    if (frame_vld)
    begin
      pl_data   <= rx_data;
      pl_stream <= rx_stream;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lpif_lpbk_stage.sv ====
/*
 * Loopback selector
 * Retimes either the local transmit lanes or the far-side lanes
 * onto the receive path
 */

`timescale 1ns/1ps
`default_nettype none

module lpif_lpbk_stage
  (
  input  logic                lclk,
  input  logic                arst_n,
  input  logic                lpbk_en,
  input  aib_pkg::lane_word_t tx_lanes,
  input  aib_pkg::lane_word_t dout,
  output aib_pkg::lane_word_t rx_lanes
  );

  aib_pkg::lane_word_t lanes_sel;

  // Local lanes in loopback, far side otherwise
  assign lanes_sel = lpbk_en ? tx_lanes : dout;

  // Cleared so the receive side sees idle frames out of reset
  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
      rx_lanes <= '0;
    else
      rx_lanes <= lanes_sel;
  end

endmodule

`default_nettype wire

// ==== hw/lpif_tx_stage.sv ====
/*
 * Transmit framing stage
 * Takes LPIF flits on irdy/trdy, maps the stream to a protocol ID and
 * registers the packed AIB lane word
 */

`timescale 1ns/1ps
`default_nettype none

module lpif_tx_stage
  #(
  parameter lpif_pkg::lpif_stream_t MEM_CACHE_STREAM_ID = 8'h01,
  parameter lpif_pkg::lpif_stream_t IO_STREAM_ID        = 8'h02,
  parameter lpif_pkg::lpif_stream_t ARB_MUX_STREAM_ID   = 8'h03
  )
  (
  input  logic                   lclk,
  input  logic                   arst_n,
  input  logic                   link_active,
  input  logic                   lp_irdy,
  input  lpif_pkg::lpif_data_t   lp_data,
  input  lpif_pkg::lpif_valid_t  lp_valid,
  input  lpif_pkg::lpif_stream_t lp_stream,
  output logic                   pl_trdy,
  output aib_pkg::lane_word_t    data_in_f,
  output logic                   pl_error
  );

  localparam int PROTID_W = $bits(lpif_pkg::protid_t);
  localparam int VALID_W  = $bits(lpif_pkg::lpif_valid_t);
  localparam int DATA_W   = $bits(lpif_pkg::lpif_data_t);

  logic                accept;
  logic                stream_known;
  lpif_pkg::protid_t   tx_protid;
  aib_pkg::lane_word_t word_d;

  assign pl_trdy = link_active;           // Only back-pressure is link state
  assign accept  = lp_irdy & link_active;

  // Stream ID to protocol ID
  always_comb
  begin
    stream_known = 1'b1;
    tx_protid    = lpif_pkg::PROTID_IDLE;
    if (lp_stream == MEM_CACHE_STREAM_ID)
      tx_protid = lpif_pkg::PROTID_MEM_CACHE;
    else if (lp_stream == IO_STREAM_ID)
      tx_protid = lpif_pkg::PROTID_IO;
    else if (lp_stream == ARB_MUX_STREAM_ID)
      tx_protid = lpif_pkg::PROTID_ARB_MUX;
    else
      stream_known = 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame packing
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    word_d = '0;                          // Idle word, padding stays zero
    if (accept && stream_known)
    begin
      word_d[aib_pkg::FRAME_PROTID_LSB +: PROTID_W] = tx_protid;
      word_d[aib_pkg::FRAME_DVALID_LSB +: VALID_W]  = lp_valid;
      word_d[aib_pkg::FRAME_DATA_LSB +: DATA_W]     = lp_data;
    end
  end

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      data_in_f <= '0;
      pl_error  <= 1'b0;
    end
    else
    begin
      data_in_f <= word_d;
      pl_error  <= accept & ~stream_known; // One cycle per dropped flit
    end
  end

endmodule

`default_nettype wire

// ==== hw/lpif_lsm.sv ====
/*
 * Link state machine
 * Walks Reset, Active and L1 with the stall exchange on L1 entry and
 * drives the registered status and link-active indications
 */

`timescale 1ns/1ps
`default_nettype none

module lpif_lsm
  (
  input  logic                 lclk,
  input  logic                 arst_n,
  input  lpif_pkg::lnk_state_e lp_state_req,
  input  logic                 fs_mac_rdy,
  input  logic                 lp_stallack,
  output lpif_pkg::lnk_state_e pl_state_sts,
  output logic                 pl_stallreq,
  output logic                 pl_phyinl1,
  output logic                 pl_lnk_up,
  output logic                 link_active
  );

  lpif_pkg::lnk_state_e state_q;
  lpif_pkg::lnk_state_e state_d;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    if (!fs_mac_rdy)
      state_d = lpif_pkg::RESET;  // Far side gone, drop the link
    else
    begin
      case (state_q)
        lpif_pkg::RESET:
          if (lp_state_req == lpif_pkg::ACTIVE)
            state_d = lpif_pkg::ACTIVE;
        lpif_pkg::ACTIVE:
          if (lp_state_req == lpif_pkg::L1)
            state_d = lpif_pkg::STALL;
        lpif_pkg::STALL:
          if (lp_stallack)
            state_d = lpif_pkg::L1;
        lpif_pkg::L1:
          if (lp_state_req == lpif_pkg::ACTIVE)
            state_d = lpif_pkg::ACTIVE;
        default:
          state_d = lpif_pkg::RESET;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State and status flops
  ////////////////////////////////////////////////////////////////////////////

  // Status is loaded from the next state so it changes with the state
  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q      <= lpif_pkg::RESET;
      pl_state_sts <= lpif_pkg::RESET;
      pl_stallreq  <= 1'b0;
      pl_phyinl1   <= 1'b0;
      pl_lnk_up    <= 1'b0;
      link_active  <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      pl_state_sts <= (state_d == lpif_pkg::STALL) ? lpif_pkg::ACTIVE : state_d;
      pl_stallreq  <= (state_d == lpif_pkg::STALL);  // Held until ack
      pl_phyinl1   <= (state_d == lpif_pkg::L1);
      pl_lnk_up    <= (state_d != lpif_pkg::RESET);
      link_active  <= (state_d == lpif_pkg::ACTIVE); // Stall and L1 block traffic
    end
  end

endmodule

`default_nettype wire

// ==== hw/aib_pkg.sv ====
/*
 * AIB lane layout
 * Lane count, lane width and the field positions of a framed flit
 */

`default_nettype none

package aib_pkg;

  localparam int AIB_LANES         = 4;
  localparam int AIB_BITS_PER_LANE = 20;

  // All lanes side by side, lane 0 in the low bits
  typedef logic [AIB_LANES*AIB_BITS_PER_LANE-1:0] lane_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Frame fields inside the lane word
  ////////////////////////////////////////////////////////////////////////////

  localparam int FRAME_PROTID_LSB = 0;  // Protocol ID, 0 means idle
  localparam int FRAME_DVALID_LSB = 2;  // Per-half valid bits
  localparam int FRAME_DATA_LSB   = 4;  // 64 data bits

  // Bits 68 and up are padding and always sent as zero

endpackage

`default_nettype wire

// ==== hw/lpif_pkg.sv ====
/*
 * LPIF link-side definitions
 * Flit data, valid and stream widths, protocol IDs and link states
 */

`default_nettype none

package lpif_pkg;

  localparam int LPIF_DATA_BYTES  = 8;
  localparam int LPIF_VALID_WIDTH = 2;  // One valid per 32-bit half

  typedef logic [LPIF_DATA_BYTES*8-1:0] lpif_data_t;
  typedef logic [LPIF_VALID_WIDTH-1:0]  lpif_valid_t;
  typedef logic [7:0]                   lpif_stream_t;

  // Protocol ID carried in the AIB frame
  typedef logic [1:0] protid_t;

  localparam protid_t PROTID_IDLE      = 2'd0;  // No flit
  localparam protid_t PROTID_MEM_CACHE = 2'd1;
  localparam protid_t PROTID_IO        = 2'd2;
  localparam protid_t PROTID_ARB_MUX   = 2'd3;

  // Link states, same codes as on pl_state_sts
  typedef enum logic [3:0]
  {
    RESET  = 4'h0,
    ACTIVE = 4'h1,
    L1     = 4'h4,
    STALL  = 4'h8   // Internal wait for stall ack, shown as ACTIVE
  } lnk_state_e;

endpackage

`default_nettype wire
